// File: all.f
+incdir+.
pong_types_pkg.sv
pong_ctrl_pkg.sv
frame_timer.sv
game_control_fsm.sv
ball_motion.sv
paddle_motion.sv
score_board.sv
pong_game.sv
pong_checker.sv
tb_pong.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_pong -f all.f
out=$(./obj_dir/Vtb_pong 2>&1) || true
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"

// File: tb_pong.sv
// Testbench for the pong game core, random and steered play checked per frame against a model
`timescale 1ns/10ps
`default_nettype none

`include "pong_config.svh"

module tb_pong
	import pong_types_pkg::*;
();

	localparam int SW = `SCREEN_WIDTH;
	localparam int BS = `BALL_SIZE;
	localparam int PW = `PADDLE_WIDTH;
	localparam int PS = `PADDLE_SPEED;
	localparam int PY = `PADDLE_Y;
	localparam int RAND_FRAMES = 150;
	localparam int FROZEN_FRAMES = 20;
	localparam int RESTART_FRAMES = 3;     // Play before the ignored restart
	localparam int GAME_LIMIT = 3000;      // Frames allowed for one game
	localparam int TOTAL_FRAMES = 2 + RAND_FRAMES + FROZEN_FRAMES + RESTART_FRAMES
		+ 5 * GAME_LIMIT;
	localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * `FRAME_CYCLES + 200;

	typedef struct packed {
		coord_t ball_x;
		coord_t ball_y;
		logic   dir_right;
		logic   dir_down;
		coord_t paddle_x;
		bcd2_t  score;
		lives_t lives;
		logic   over;
		bcd2_t  game_num;
		bcd2_t  best_score_1;
		bcd2_t  best_score_2;
		bcd2_t  best_score_3;
		bcd2_t  best_game_1;
		bcd2_t  best_game_2;
		bcd2_t  best_game_3;
	} model_t;

	logic   Clock_25;
	logic   system_resetn;
	logic   restart;
	logic   move_right;
	logic   move_left;
	logic   serve_right;
	logic   serve_down;
	speed_t ball_speed;
	logic   frame_tick;
	coord_t ball_x;
	coord_t ball_y;
	logic   ball_dir_right;
	logic   ball_dir_down;
	coord_t paddle_x;
	bcd2_t  score;
	lives_t lives;
	logic   game_over;
	bcd2_t  best_score_1;
	bcd2_t  best_score_2;
	bcd2_t  best_score_3;
	bcd2_t  best_game_1;
	bcd2_t  best_game_2;
	bcd2_t  best_game_3;

	model_t model;
	int     cycle_count = 0;
	int     errors = 0;
	int     error_mark = 0;
	int     checks = 0;
	int     tests_passed = 0;
	int     tests_failed = 0;
	int     test_num = 1;
	logic   timed_out = 1'b0;

	pong_game dut_i (.*);

	initial begin
		Clock_25 = 1'b0;
		forever #2 Clock_25 = ~Clock_25;
	end

	always @(posedge Clock_25) cycle_count <= cycle_count + 1;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic int bcd_value(input bcd2_t v);
		return 10 * int'(v[7:4]) + int'(v[3:0]);
	endfunction

	function automatic bcd2_t bcd_next(input bcd2_t v);
		int n;
		n = (bcd_value(v) + 1) % 100;   // 99 wraps to 00
		return {4'(n / 10), 4'(n % 10)};
	endfunction

	function automatic model_t reset_model();
		model_t m;
		m = '0;
		m.ball_x = coord_t'(`BALL_START_X);
		m.ball_y = coord_t'(`BALL_START_Y);
		m.dir_right = 1'b1;
		m.dir_down = 1'b1;
		m.paddle_x = coord_t'(`PADDLE_START_X);
		m.lives = lives_t'(`START_LIVES);
		m.game_num = 8'h01;
		m.best_game_1 = 8'h01;
		m.best_game_2 = 8'h01;
		m.best_game_3 = 8'h01;
		return m;
	endfunction

	// New game keeps the game number and the leaderboard
	function automatic model_t restart_model(input model_t m);
		model_t n;
		n = reset_model();
		n.game_num = m.game_num;
		n.best_score_1 = m.best_score_1;
		n.best_score_2 = m.best_score_2;
		n.best_score_3 = m.best_score_3;
		n.best_game_1 = m.best_game_1;
		n.best_game_2 = m.best_game_2;
		n.best_game_3 = m.best_game_3;
		return n;
	endfunction

	function automatic model_t rank_entry(input model_t m, input bcd2_t sc, input bcd2_t gn);
		model_t n;
		int v;
		n = m;
		v = bcd_value(sc);
		if (v >= bcd_value(m.best_score_1)) begin
			n.best_score_3 = m.best_score_2;
			n.best_game_3 = m.best_game_2;
			n.best_score_2 = m.best_score_1;
			n.best_game_2 = m.best_game_1;
			n.best_score_1 = sc;
			n.best_game_1 = gn;
		end else if (v >= bcd_value(m.best_score_2)) begin
			n.best_score_3 = m.best_score_2;
			n.best_game_3 = m.best_game_2;
			n.best_score_2 = sc;
			n.best_game_2 = gn;
		end else if (v >= bcd_value(m.best_score_3)) begin
			n.best_score_3 = sc;
			n.best_game_3 = gn;
		end
		return n;
	endfunction

	function automatic model_t step_frame(input model_t m, input logic right_btn,
			input logic left_btn, input logic srv_right, input logic srv_down, input speed_t spd);
		model_t n;
		int s;
		int x;
		int y;
		int px;
		n = m;
		s = int'(spd);
		x = int'(m.ball_x);
		y = int'(m.ball_y);
		px = int'(m.paddle_x);
		if (right_btn) begin
			if (px < SW - PW - PS) n.paddle_x = coord_t'(px + PS);
		end else if (left_btn && px > PS) begin
			n.paddle_x = coord_t'(px - PS);
		end
		if (!m.over) begin
			if (m.dir_right) begin
				if (x < SW - BS - s) n.ball_x = coord_t'(x + s);
				else n.dir_right = 1'b0;
			end else if (x >= s) begin
				n.ball_x = coord_t'(x - s);
			end else begin
				n.dir_right = 1'b1;
			end
			if (!m.dir_down) begin
				if (y >= s) n.ball_y = coord_t'(y - s);
				else n.dir_down = 1'b1;
			end else if (y <= PY - BS - s) begin
				n.ball_y = coord_t'(y + s);
			end else if (x >= px && x + BS <= px + PW) begin
				n.dir_down = 1'b0;             // Paddle hit
				n.score = bcd_next(m.score);
			end else begin
				n.ball_x = coord_t'(`BALL_START_X);
				n.ball_y = coord_t'(`BALL_START_Y);
				n.dir_right = srv_right;
				n.dir_down = srv_down;
				if (m.lives != 0) n.lives = lives_t'(int'(m.lives) - 1);
				if (m.lives == 1) begin
					n.over = 1'b1;
					n.game_num = bcd_next(m.game_num);
					n = rank_entry(n, m.score, m.game_num);
				end
			end
		end
		return n;
	endfunction

	////////////////////////////////////////
	// Checks and reporting
	////////////////////////////////////////
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual == expected) else begin
			errors++;
			$display("ERROR: %s expected 0x%0h actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	task automatic check_outputs();
		check_value("ball_x", 32'(model.ball_x), 32'(ball_x));
		check_value("ball_y", 32'(model.ball_y), 32'(ball_y));
		check_value("ball_dir_right", 32'(model.dir_right), 32'(ball_dir_right));
		check_value("ball_dir_down", 32'(model.dir_down), 32'(ball_dir_down));
		check_value("paddle_x", 32'(model.paddle_x), 32'(paddle_x));
		check_value("score", 32'(model.score), 32'(score));
		check_value("lives", 32'(model.lives), 32'(lives));
		check_value("game_over", 32'(model.over), 32'(game_over));
		check_value("best_score_1", 32'(model.best_score_1), 32'(best_score_1));
		check_value("best_score_2", 32'(model.best_score_2), 32'(best_score_2));
		check_value("best_score_3", 32'(model.best_score_3), 32'(best_score_3));
		check_value("best_game_1", 32'(model.best_game_1), 32'(best_game_1));
		check_value("best_game_2", 32'(model.best_game_2), 32'(best_game_2));
		check_value("best_game_3", 32'(model.best_game_3), 32'(best_game_3));
	endtask

	// Start values straight from the config macros
	task automatic check_start_values();
		check_value("ball_x", `BALL_START_X, 32'(ball_x));
		check_value("ball_y", `BALL_START_Y, 32'(ball_y));
		check_value("ball_dir_right", 1, 32'(ball_dir_right));
		check_value("ball_dir_down", 1, 32'(ball_dir_down));
		check_value("paddle_x", `PADDLE_START_X, 32'(paddle_x));
		check_value("score", 0, 32'(score));
		check_value("lives", `START_LIVES, 32'(lives));
		check_value("game_over", 0, 32'(game_over));
	endtask

	task automatic end_test(input string name);
		if (errors == error_mark) begin
			tests_passed++;
			$display("Test %0d %s: passed", test_num, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", test_num, name, errors - error_mark);
		end
		test_num++;
		error_mark = errors;
	endtask

	task automatic finish_run();
		$display("Tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0 && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	// Model steps on the negedge of a tick or restart cycle, outputs checked one cycle later
	initial begin
		logic pending;
		pending = 1'b0;
		model = reset_model();
		wait (system_resetn);
		forever begin
			@(negedge Clock_25);
			if (pending) check_outputs();
			pending = 1'b1;
			if (restart && model.over) begin
				model = restart_model(model);
			end else if (frame_tick) begin
				model = step_frame(model, move_right, move_left, serve_right, serve_down,
					ball_speed);
			end else begin
				pending = 1'b0;
			end
		end
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		timed_out = 1'b1;
		finish_run();
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	task automatic wait_frame();
		@(negedge Clock_25);
		while (!frame_tick) @(negedge Clock_25);
		@(posedge Clock_25);
		#1;   // Just past the update edge
	endtask

	task automatic drive_random();
		move_right = 1'($urandom);
		move_left = 1'($urandom);
		serve_right = 1'($urandom);
		serve_down = 1'($urandom);
		ball_speed = speed_t'(1 + $urandom % 7);
	endtask

	task automatic pulse_restart();
		restart = 1'b1;
		@(posedge Clock_25);
		#1;
		restart = 1'b0;
	endtask

	// Follows the ball until enough hits, then keeps the paddle away from it
	task automatic play_game(input int hits_wanted);
		int frames;
		frames = 0;
		while (!model.over && frames < GAME_LIMIT) begin
			serve_right = 1'($urandom);
			serve_down = 1'($urandom);
			if (bcd_value(model.score) < hits_wanted) begin
				ball_speed = speed_t'(PS);   // Paddle keeps pace at this speed
				move_right = int'(model.ball_x) > int'(model.paddle_x) + 25;
				move_left = int'(model.ball_x) < int'(model.paddle_x) + 25;
			end else begin
				ball_speed = speed_t'(1 + $urandom % 7);
				move_right = int'(model.ball_x) < SW / 2;
				move_left = !move_right;
			end
			wait_frame();
			frames++;
		end
		expect_true(model.over, "Game did not end within the frame limit");
	endtask

	initial begin
		int     release_cycle;
		int     tick_at;
		coord_t frozen_x;
		coord_t frozen_y;
		void'($urandom(32'hdf4c));
		system_resetn = 1'b0;
		restart = 1'b0;
		move_right = 1'b0;
		move_left = 1'b0;
		serve_right = 1'b0;
		serve_down = 1'b0;
		ball_speed = speed_t'(1);
		repeat (10) @(posedge Clock_25);
		#1;
		system_resetn = 1'b1;
		release_cycle = cycle_count;

		@(negedge Clock_25);
		check_outputs();
		while (!frame_tick) @(negedge Clock_25);
		check_value("tick_delay", `FRAME_CYCLES, 32'(cycle_count - release_cycle + 1));
		tick_at = cycle_count;
		@(negedge Clock_25);
		while (!frame_tick) @(negedge Clock_25);
		check_value("tick_period", `FRAME_CYCLES, 32'(cycle_count - tick_at));
		@(posedge Clock_25);
		#1;
		end_test("reset values and frame timing");

		repeat (RAND_FRAMES) begin
			drive_random();
			wait_frame();
		end
		end_test("random motion");

		play_game(0);
		frozen_x = model.ball_x;
		frozen_y = model.ball_y;
		repeat (FROZEN_FRAMES) begin
			drive_random();
			wait_frame();
		end
		check_value("ball_x", 32'(frozen_x), 32'(ball_x));
		check_value("ball_y", 32'(frozen_y), 32'(ball_y));
		end_test("game over and frozen ball");

		pulse_restart();
		@(negedge Clock_25);
		check_start_values();
		@(posedge Clock_25);
		#1;
		// Move the ball off its start point first
		repeat (RESTART_FRAMES) begin
			drive_random();
			wait_frame();
		end
		pulse_restart();   // Now playing, so ignored
		@(negedge Clock_25);
		check_outputs();
		@(posedge Clock_25);
		#1;
		end_test("restart");

		play_game(11);
		expect_true(bcd_value(model.score) >= 10, "Score never carried from 09 to 10");
		end_test("hits, BCD carry and misses");

		// Low and equal scores exercise the tie rule
		pulse_restart();
		play_game(1);
		pulse_restart();
		play_game(0);
		pulse_restart();
		play_game(0);
		end_test("leaderboard over several games");

		finish_run();
	end

endmodule

`default_nettype wire

// File: pong_checker.sv
// Concurrent checks on frame strobes, game pulses and lives, bound into the pong game top level
`timescale 1ns/10ps
`default_nettype none

module pong_checker
	import pong_types_pkg::*, pong_ctrl_pkg::*;
(
	input logic   Clock_25,
	input logic   system_resetn,
	input logic   frame_tick,
	input logic   new_game,
	input logic   game_end,
	input logic   game_over,
	input lives_t lives
);

	game_state_t state_seen;

	assign state_seen = game_over ? GAME_OVER : PLAYING;

	////////////////////////////////////////
	// Properties
	////////////////////////////////////////
	a_single_tick: assert property (@(posedge Clock_25) disable iff (!system_resetn)
		frame_tick |=> !frame_tick)
		else $error("frame_tick high in two consecutive cycles");

	a_pulses_apart: assert property (@(posedge Clock_25) disable iff (!system_resetn)
		!(new_game && game_end))
		else $error("new_game and game_end in the same cycle");

	// Lives only move on a frame or a new game
	a_lives_steady: assert property (@(posedge Clock_25) disable iff (!system_resetn)
		(!frame_tick && !new_game) |=> $stable(lives))
		else $error("lives changed outside a frame tick or new game");

	// Losing the last life ends the game on the same edge
	a_lives_in_play: assert property (@(posedge Clock_25) disable iff (!system_resetn)
		(state_seen == PLAYING) |-> (lives != '0))
		else $error("lives reached zero while still playing");

endmodule

bind pong_game pong_checker checker_i (
	.Clock_25      (Clock_25),
	.system_resetn (system_resetn),
	.frame_tick    (frame_tick),
	.new_game      (new_game),
	.game_end      (game_end),
	.game_over     (game_over),
	.lives         (lives)
);

`default_nettype wire

// File: pong_game.sv
// Top level of the game core, joins the frame timer, control FSM and data blocks
`timescale 1ns/10ps
`default_nettype none

module pong_game
	import pong_types_pkg::*;
(
	input  logic   Clock_25,
	input  logic   system_resetn,
	input  logic   restart,
	input  logic   move_right,
	input  logic   move_left,
	input  logic   serve_right,
	input  logic   serve_down,
	input  speed_t ball_speed,
	output logic   frame_tick,
	output coord_t ball_x,
	output coord_t ball_y,
	output logic   ball_dir_right,
	output logic   ball_dir_down,
	output coord_t paddle_x,
	output bcd2_t  score,
	output lives_t lives,
	output logic   game_over,
	output bcd2_t  best_score_1,
	output bcd2_t  best_score_2,
	output bcd2_t  best_score_3,
	output bcd2_t  best_game_1,
	output bcd2_t  best_game_2,
	output bcd2_t  best_game_3
);

	logic playing;
	logic new_game;
	logic game_end;
	logic hit;      // From the paddle test
	logic miss;

	frame_timer frame_timer_i (
		.Clock_25      (Clock_25),
		.system_resetn (system_resetn),
		.frame_tick    (frame_tick)
	);

	game_control_fsm game_control_fsm_i (
		.Clock_25      (Clock_25),
		.system_resetn (system_resetn),
		.frame_tick    (frame_tick),
		.miss          (miss),
		.lives         (lives),
		.restart       (restart),
		.playing       (playing),
		.game_over     (game_over),
		.new_game      (new_game),
		.game_end      (game_end)
	);

	ball_motion ball_motion_i (
		.Clock_25       (Clock_25),
		.system_resetn  (system_resetn),
		.frame_tick     (frame_tick),
		.playing        (playing),
		.new_game       (new_game),
		.ball_speed     (ball_speed),
		.serve_right    (serve_right),
		.serve_down     (serve_down),
		.paddle_x       (paddle_x),
		.ball_x         (ball_x),
		.ball_y         (ball_y),
		.ball_dir_right (ball_dir_right),
		.ball_dir_down  (ball_dir_down),
		.hit            (hit),
		.miss           (miss)
	);

	paddle_motion paddle_motion_i (
		.Clock_25      (Clock_25),
		.system_resetn (system_resetn),
		.frame_tick    (frame_tick),
		.new_game      (new_game),
		.move_right    (move_right),
		.move_left     (move_left),
		.paddle_x      (paddle_x)
	);

	score_board score_board_i (
		.Clock_25      (Clock_25),
		.system_resetn (system_resetn),
		.frame_tick    (frame_tick),
		.hit           (hit),
		.miss          (miss),
		.new_game      (new_game),
		.game_end      (game_end),
		.score         (score),
		.lives         (lives),
		.best_score_1  (best_score_1),
		.best_score_2  (best_score_2),
		.best_score_3  (best_score_3),
		.best_game_1   (best_game_1),
		.best_game_2   (best_game_2),
		.best_game_3   (best_game_3)
	);

endmodule

`default_nettype wire

// File: score_board.sv
// BCD score, lives, game number and the three best scores with the games that made them
`timescale 1ns/10ps
`default_nettype none

`include "pong_config.svh"

module score_board
	import pong_types_pkg::*;
(
	input  logic   Clock_25,
	input  logic   system_resetn,
	input  logic   frame_tick,
	input  logic   hit,
	input  logic   miss,
	input  logic   new_game,
	input  logic   game_end,
	output bcd2_t  score,
	output lives_t lives,
	output bcd2_t  best_score_1,
	output bcd2_t  best_score_2,
	output bcd2_t  best_score_3,
	output bcd2_t  best_game_1,
	output bcd2_t  best_game_2,
	output bcd2_t  best_game_3
);

	bcd2_t game_num;   // Number of the game in progress

	// Two-digit BCD increment, 99 wraps to 00
	function automatic bcd2_t bcd_inc(input bcd2_t value);
		bcd2_t result;
		if (value[3:0] == 4'd9) begin
			result[3:0] = 4'd0;
			result[7:4] = (value[7:4] == 4'd9) ? 4'd0 : value[7:4] + 4'd1;
		end else begin
			result = {value[7:4], value[3:0] + 4'd1};
		end
		return result;
	endfunction

	////////////////////////////////////////
	// Current game
	////////////////////////////////////////
	always_ff @(posedge Clock_25 or negedge system_resetn) begin
		if (!system_resetn) begin
			score <= '0;
			lives <= lives_t'(`START_LIVES);
		end else if (new_game) begin
			score <= '0;
			lives <= lives_t'(`START_LIVES);
		end else if (frame_tick) begin
			if (hit) score <= bcd_inc(score);
			if (miss && lives != '0) lives <= lives - 1'b1;   // Floor at zero
		end
	end

	////////////////////////////////////////
	// Leaderboard and game number
	////////////////////////////////////////
	always_ff @(posedge Clock_25 or negedge system_resetn) begin
		if (!system_resetn) begin
			game_num     <= 8'h01;
			best_score_1 <= '0;
			best_score_2 <= '0;
			best_score_3 <= '0;
			best_game_1  <= 8'h01;
			best_game_2  <= 8'h01;
			best_game_3  <= 8'h01;
		end else if (game_end) begin
			game_num <= bcd_inc(game_num);
			// Ties go to the newer game
			if (score >= best_score_1) begin
				best_score_3 <= best_score_2;
				best_game_3  <= best_game_2;
				best_score_2 <= best_score_1;
				best_game_2  <= best_game_1;
				best_score_1 <= score;
				best_game_1  <= game_num;
			end else if (score >= best_score_2) begin
				best_score_3 <= best_score_2;
				best_game_3  <= best_game_2;
				best_score_2 <= score;
				best_game_2  <= game_num;
			end else if (score >= best_score_3) begin
				best_score_3 <= score;
				best_game_3  <= game_num;
			end
		end
	end

endmodule

`default_nettype wire

// File: paddle_motion.sv
// Paddle horizontal position, stepped each frame by the two move buttons
`timescale 1ns/10ps
`default_nettype none

`include "pong_config.svh"

module paddle_motion
	import pong_types_pkg::*;
(
	input  logic   Clock_25,
	input  logic   system_resetn,
	input  logic   frame_tick,
	input  logic   new_game,
	input  logic   move_right,
	input  logic   move_left,
	output coord_t paddle_x
);

	localparam coord_t STEP    = coord_t'(`PADDLE_SPEED);
	localparam coord_t R_LIMIT = coord_t'(`SCREEN_WIDTH - `PADDLE_WIDTH - `PADDLE_SPEED);
	localparam coord_t START_X = coord_t'(`PADDLE_START_X);

	always_ff @(posedge Clock_25 or negedge system_resetn) begin
		if (!system_resetn) begin
			paddle_x <= START_X;
		end else if (new_game) begin
			paddle_x <= START_X;
		end else if (frame_tick) begin
			// Right button wins even when blocked
			if (move_right) begin
				if (paddle_x < R_LIMIT) paddle_x <= paddle_x + STEP;
			end else if (move_left) begin
				if (paddle_x > STEP) paddle_x <= paddle_x - STEP;
			end
		end
	end

endmodule

`default_nettype wire

// File: ball_motion.sv
// Ball position and direction per frame, with wall bounces and the paddle hit and miss test
`timescale 1ns/10ps
`default_nettype none

`include "pong_config.svh"

module ball_motion
	import pong_types_pkg::*;
(
	input  logic   Clock_25,
	input  logic   system_resetn,
	input  logic   frame_tick,
	input  logic   playing,
	input  logic   new_game,
	input  speed_t ball_speed,
	input  logic   serve_right,
	input  logic   serve_down,
	input  coord_t paddle_x,
	output coord_t ball_x,
	output coord_t ball_y,
	output logic   ball_dir_right,
	output logic   ball_dir_down,
	output logic   hit,
	output logic   miss
);

	localparam coord_t X_LIMIT  = coord_t'(`SCREEN_WIDTH - `BALL_SIZE);
	localparam coord_t Y_LIMIT  = coord_t'(`PADDLE_Y - `BALL_SIZE);   // Lowest free row
	localparam coord_t BALL_SZ  = coord_t'(`BALL_SIZE);
	localparam coord_t PAD_W    = coord_t'(`PADDLE_WIDTH);
	localparam coord_t START_X  = coord_t'(`BALL_START_X);
	localparam coord_t START_Y  = coord_t'(`BALL_START_Y);

	coord_t speed;
	logic   at_bottom;
	logic   over_paddle;

	assign speed = coord_t'(ball_speed);

	////////////////////////////////////////
	// Paddle test on the current position
	////////////////////////////////////////
	always_comb begin
		at_bottom   = ball_dir_down && (ball_y > Y_LIMIT - speed);
		over_paddle = (ball_x >= paddle_x) && (ball_x + BALL_SZ <= paddle_x + PAD_W);
		hit         = playing && at_bottom && over_paddle;
		miss        = playing && at_bottom && !over_paddle;
	end

	////////////////////////////////////////
	// Position and direction registers
	////////////////////////////////////////
	always_ff @(posedge Clock_25 or negedge system_resetn) begin
		if (!system_resetn) begin
			ball_x         <= START_X;
			ball_y         <= START_Y;
			ball_dir_right <= 1'b1;
			ball_dir_down  <= 1'b1;
		end else if (new_game) begin
			ball_x         <= START_X;
			ball_y         <= START_Y;
			ball_dir_right <= 1'b1;
			ball_dir_down  <= 1'b1;
		end else if (frame_tick && playing) begin
			if (miss) begin
				// Respawn overrides the horizontal step
				ball_x         <= START_X;
				ball_y         <= START_Y;
				ball_dir_right <= serve_right;
				ball_dir_down  <= serve_down;
			end else begin
				if (ball_dir_right) begin
					if (ball_x < X_LIMIT - speed) ball_x <= ball_x + speed;
					else                          ball_dir_right <= 1'b0;   // Right wall
				end else begin
					if (ball_x >= speed) ball_x <= ball_x - speed;
					else                 ball_dir_right <= 1'b1;   // Left wall
				end

				if (hit) begin
					ball_dir_down <= 1'b0;   // Bounce off paddle
				end else if (ball_dir_down) begin
					ball_y <= ball_y + speed;
				end else if (ball_y >= speed) begin
					ball_y <= ball_y - speed;
				end else begin
					ball_dir_down <= 1'b1;   // Top wall
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: game_control_fsm.sv
// Playing and game-over state machine, issues the new-game and game-end pulses
`timescale 1ns/10ps
`default_nettype none

module game_control_fsm
	import pong_types_pkg::*, pong_ctrl_pkg::*;
(
	input  logic   Clock_25,
	input  logic   system_resetn,
	input  logic   frame_tick,
	input  logic   miss,
	input  lives_t lives,
	input  logic   restart,
	output logic   playing,
	output logic   game_over,
	output logic   new_game,
	output logic   game_end
);

	game_state_t state;

	assign playing   = (state == PLAYING);
	assign game_over = (state == GAME_OVER);

	// Last life lost on this frame
	assign game_end = playing && frame_tick && miss && (lives == lives_t'(1));
	assign new_game = game_over && restart;   // Restart only counts in game over

	always_ff @(posedge Clock_25 or negedge system_resetn) begin
		if (!system_resetn) begin
			state <= PLAYING;
		end else begin
			case (state)
				PLAYING:   if (game_end) state <= GAME_OVER;
				GAME_OVER: if (new_game) state <= PLAYING;
				default:   state <= PLAYING;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: frame_timer.sv
// Free-running cycle counter giving one update strobe per frame to the game core
`timescale 1ns/10ps
`default_nettype none

`include "pong_config.svh"

module frame_timer (
	input  logic Clock_25,
	input  logic system_resetn,
	output logic frame_tick
);

	localparam int CNT_W = $clog2(`FRAME_CYCLES);
	localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(`FRAME_CYCLES - 1);

	logic [CNT_W-1:0] cycle_cnt;

	assign frame_tick = (cycle_cnt == LAST_CYCLE);   // One cycle per frame

	always_ff @(posedge Clock_25 or negedge system_resetn) begin
		if (!system_resetn) begin
			cycle_cnt <= '0;
		end else if (frame_tick) begin
			cycle_cnt <= '0;   // Wrap at end of frame
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: pong_ctrl_pkg.sv
// Game control state encoding, shared by the control FSM and the checker
`default_nettype none

package pong_ctrl_pkg;

	typedef enum logic {
		PLAYING   = 1'b0,
		GAME_OVER = 1'b1
	} game_state_t;

endpackage

`default_nettype wire

// File: pong_types_pkg.sv
// Vector types for coordinates, speed, BCD values and lives, imported by the game RTL
`default_nettype none

`include "pong_config.svh"

package pong_types_pkg;

	// Screen coordinate, x or y
	typedef logic [`POS_WIDTH-1:0] coord_t;

	// Ball speed in pixels per frame
	typedef logic [2:0] speed_t;

	// Two BCD digits, tens in the upper nibble
	typedef logic [7:0] bcd2_t;

	typedef logic [1:0] lives_t;    // Remaining lives, 0 to 3

endpackage

`default_nettype wire

// File: pong_config.svh
// Game geometry, speeds, start values and frame length, included by the RTL and the testbench
`ifndef PONG_CONFIG_SVH
`define PONG_CONFIG_SVH

// Screen and coordinates
`define POS_WIDTH       10
`define SCREEN_WIDTH    640
`define SCREEN_HEIGHT   480

// Object sizes in pixels
`define BALL_SIZE       10
`define PADDLE_WIDTH    60
`define PADDLE_HEIGHT   5
`define PADDLE_SPEED    5       // Pixels per frame
`define BOTTOM_MARGIN   50      // Gap below the paddle

// Start values
`define BALL_START_X    200
`define BALL_START_Y    50
`define PADDLE_START_X  200
`define START_LIVES     3

`define FRAME_CYCLES    64      // Short frame for simulation
`define PADDLE_Y        (`SCREEN_HEIGHT - `PADDLE_HEIGHT - `BOTTOM_MARGIN)

`endif
